//--- source/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// ===========================================================================
// Cache geometry
// ===========================================================================

// Byte offset bits within a line.
// Sixteen bytes per line, so four words.
`define DCACHE_OFFSET_BITS 4

// Set index bits.
`define DCACHE_INDEX_BITS 2 // Four sets.

// Associativity.
// The victim hash in the tag store assumes a 2-bit way number.
`define DCACHE_WAYS 4

`endif

//--- source/bus_pkg.sv
package bus_pkg;

    // ===========================================================================
    // Core data bus and memory burst bus
    // ===========================================================================

    // Byte address, shared by both buses.
    typedef logic [31:0] addr_t;

    // One data word.
    typedef logic [31:0] word_t;

    // Byte enables on the data bus.
    // All zero marks a read.
    typedef logic [3:0] strobe_t;

endpackage

//--- source/cache_pkg.sv
`include "dcache_defs.svh"

package cache_pkg;

    // ===========================================================================
    // Address fields
    // ===========================================================================

    typedef logic [31-`DCACHE_OFFSET_BITS-`DCACHE_INDEX_BITS:0] tag_t;
    typedef logic [`DCACHE_INDEX_BITS-1:0] index_t;
    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;
    typedef logic [`DCACHE_OFFSET_BITS-3:0] word_sel_t; // Word within a line.

    // ===========================================================================
    // Controller
    // ===========================================================================

    typedef enum logic [2:0] {
        idle,      // Waiting for a request.
        lookup,    // Tag compare.
        writeback, // Dirty victim burst out.
        refill,    // Line burst in.
        update,    // Apply the pending write after a refill.
        respond    // One cycle of data_ok.
    } cache_state_t;

endpackage

//--- source/dcache_tag_store.sv
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_tag_store (
    input  logic              clk,
    input  logic              resetn,
    input  cache_pkg::index_t index,
    input  cache_pkg::tag_t   tag,
    output logic              hit,
    output cache_pkg::way_t   hit_way,
    output cache_pkg::way_t   victim_way,
    output cache_pkg::tag_t   victim_tag,
    output logic              victim_dirty,
    input  logic              meta_we,
    input  cache_pkg::way_t   meta_way,
    input  cache_pkg::tag_t   meta_tag,
    input  logic              meta_valid,
    input  logic              meta_dirty
);
    import cache_pkg::*;

    localparam int SETS = 1 << `DCACHE_INDEX_BITS;
    localparam int WAYS = `DCACHE_WAYS;

    tag_t tags  [SETS][WAYS];
    logic valid [SETS][WAYS];
    logic dirty [SETS][WAYS];

    logic any_invalid;
    way_t free_way;
    way_t hash_way;

    // Parallel compare of all ways.
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid[index][w] && tags[index][w] == tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // Lowest invalid way, scanned downwards so the last match wins.
    always_comb begin
        any_invalid = 1'b0;
        free_way    = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!valid[index][w]) begin
                any_invalid = 1'b1;
                free_way    = way_t'(w);
            end
        end
    end

    // Set full: fold the tag down to a way number.
    always_comb begin
        hash_way = '0;
        for (int i = 0; i < $bits(tag_t) / $bits(way_t); i++) begin
            hash_way = hash_way ^ tag[i*$bits(way_t) +: $bits(way_t)];
        end
    end

    assign victim_way   = any_invalid ? free_way : hash_way;
    assign victim_tag   = tags[index][victim_way];
    assign victim_dirty = valid[index][victim_way] && dirty[index][victim_way];

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    valid[s][w] <= 1'b0;
                    dirty[s][w] <= 1'b0;
                end
            end
        end else if (meta_we) begin
            valid[index][meta_way] <= meta_valid;
            dirty[index][meta_way] <= meta_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (meta_we) begin
            tags[index][meta_way] <= meta_tag;
        end
    end

endmodule

//--- source/dcache_data_store.sv
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_data_store (
    input  logic                 clk,
    input  cache_pkg::index_t    rd_index,
    input  cache_pkg::way_t      rd_way,
    input  cache_pkg::word_sel_t rd_sel,
    output bus_pkg::word_t       rd_word,
    input  logic                 wr_en,
    input  cache_pkg::index_t    wr_index,
    input  cache_pkg::way_t      wr_way,
    input  cache_pkg::word_sel_t wr_sel,
    input  bus_pkg::strobe_t     wr_mask,
    input  bus_pkg::word_t       wr_word
);
    import bus_pkg::*;

    localparam int SETS  = 1 << `DCACHE_INDEX_BITS;
    localparam int WAYS  = `DCACHE_WAYS;
    localparam int WORDS = 1 << (`DCACHE_OFFSET_BITS - 2);

    word_t mem [SETS][WAYS][WORDS];

    // Asynchronous read.
    // Serves hit data and the writeback burst.
    assign rd_word = mem[rd_index][rd_way][rd_sel];

    // Byte merge under the mask.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < $bits(strobe_t); b++) begin
                if (wr_mask[b]) begin
                    mem[wr_index][wr_way][wr_sel][8*b +: 8] <= wr_word[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- source/dcache_ctrl.sv
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_ctrl (
    input  logic                 clk,
    input  logic                 resetn,
    // Core data bus.
    input  logic                 dreq_valid,
    input  bus_pkg::addr_t       dreq_addr,
    input  bus_pkg::strobe_t     dreq_strobe,
    input  bus_pkg::word_t       dreq_data,
    output logic                 dresp_addr_ok,
    output logic                 dresp_data_ok,
    output bus_pkg::word_t       dresp_data,
    // Memory burst bus.
    output logic                 creq_valid,
    output logic                 creq_is_write,
    output bus_pkg::addr_t       creq_addr,
    output bus_pkg::word_t       creq_data,
    input  logic                 cresp_ready,
    input  logic                 cresp_last,
    input  bus_pkg::word_t       cresp_data,
    // Tag store.
    output cache_pkg::index_t    lookup_index,
    output cache_pkg::tag_t      lookup_tag,
    input  logic                 hit,
    input  cache_pkg::way_t      hit_way,
    input  cache_pkg::way_t      victim_way,
    input  cache_pkg::tag_t      victim_tag,
    input  logic                 victim_dirty,
    output logic                 meta_we,
    output cache_pkg::way_t      meta_way,
    output cache_pkg::tag_t      meta_tag,
    output logic                 meta_valid,
    output logic                 meta_dirty,
    // Data store.
    output cache_pkg::index_t    rd_index,
    output cache_pkg::way_t      rd_way,
    output cache_pkg::word_sel_t rd_sel,
    input  bus_pkg::word_t       rd_word,
    output logic                 wr_en,
    output cache_pkg::index_t    wr_index,
    output cache_pkg::way_t      wr_way,
    output cache_pkg::word_sel_t wr_sel,
    output bus_pkg::strobe_t     wr_mask,
    output bus_pkg::word_t       wr_word
);
    import bus_pkg::*;
    import cache_pkg::*;

    localparam int OB = `DCACHE_OFFSET_BITS;
    localparam int IB = `DCACHE_INDEX_BITS;

    cache_state_t state;

    tag_t      req_tag;
    index_t    req_index;
    word_sel_t req_sel;
    strobe_t   req_strobe;
    word_t     req_data;
    way_t      req_way;   // Hit way or victim, fixed after lookup.
    tag_t      wb_tag;
    word_sel_t cnt;       // Burst word counter.

    logic is_write;
    way_t lookup_way;

    assign is_write   = |req_strobe;
    assign lookup_way = hit ? hit_way : victim_way;

    // ===========================================================================
    // Request and miss registers
    // ===========================================================================

    always_ff @(posedge clk) begin
        if (state == idle && dreq_valid) begin
            req_tag    <= dreq_addr[31:OB+IB];
            req_index  <= dreq_addr[OB+IB-1:OB];
            req_sel    <= dreq_addr[OB-1:2];
            req_strobe <= dreq_strobe;
            req_data   <= dreq_data;
        end
        if (state == lookup) begin
            req_way <= lookup_way;
            wb_tag  <= victim_tag;
        end
    end

    // ===========================================================================
    // State machine
    // ===========================================================================

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= idle;
            cnt   <= '0;
        end else begin
            case (state)
                idle: begin
                    if (dreq_valid) begin
                        state <= lookup;
                    end
                end
                lookup: begin
                    cnt <= '0;
                    if (hit) begin
                        state <= respond;
                    end else if (victim_dirty) begin
                        state <= writeback;
                    end else begin
                        state <= refill;
                    end
                end
                writeback: begin
                    if (cresp_ready) begin
                        cnt <= cnt + 1'b1;
                        if (cresp_last) begin
                            cnt   <= '0;
                            state <= refill;
                        end
                    end
                end
                refill: begin
                    if (cresp_ready) begin
                        cnt <= cnt + 1'b1;
                        if (cresp_last) begin
                            cnt   <= '0;
                            state <= update;
                        end
                    end
                end
                update:  state <= respond;
                respond: state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // Bus outputs.
    assign dresp_addr_ok = state == idle;
    assign dresp_data_ok = state == respond;
    assign dresp_data    = rd_word;

    assign creq_valid    = state == writeback || state == refill;
    assign creq_is_write = state == writeback;
    assign creq_addr     = {creq_is_write ? wb_tag : req_tag, req_index, {OB{1'b0}}};
    assign creq_data     = rd_word; // Victim word at cnt.

    assign lookup_index = req_index;
    assign lookup_tag   = req_tag;

    // A miss drops the victim in lookup, update installs the new line.
    assign meta_we    = (state == lookup && (!hit || is_write)) || state == update;
    assign meta_way   = (state == lookup) ? lookup_way : req_way;
    assign meta_tag   = req_tag;
    assign meta_valid = state != lookup || hit;
    assign meta_dirty = (state == lookup) ? hit : is_write;

    assign rd_index = req_index;
    assign rd_way   = req_way;
    assign rd_sel   = (state == writeback) ? cnt : req_sel;

    assign wr_en    = (state == lookup && hit && is_write)
                    || (state == refill && cresp_ready)
                    || (state == update && is_write);
    assign wr_index = req_index;
    assign wr_way   = (state == lookup) ? hit_way : req_way;
    assign wr_sel   = (state == refill) ? cnt : req_sel;
    assign wr_mask  = (state == refill) ? '1 : req_strobe;
    assign wr_word  = (state == refill) ? cresp_data : req_data;

endmodule

//--- source/dcache.sv
`timescale 1ns/1ns

module dcache (
    input  logic             clk,
    input  logic             resetn,
    input  logic             dreq_valid,
    input  bus_pkg::addr_t   dreq_addr,
    input  bus_pkg::strobe_t dreq_strobe,
    input  bus_pkg::word_t   dreq_data,
    output logic             dresp_addr_ok,
    output logic             dresp_data_ok,
    output bus_pkg::word_t   dresp_data,
    output logic             creq_valid,
    output logic             creq_is_write,
    output bus_pkg::addr_t   creq_addr,
    output bus_pkg::word_t   creq_data,
    input  logic             cresp_ready,
    input  logic             cresp_last,
    input  bus_pkg::word_t   cresp_data
);
    import bus_pkg::*;
    import cache_pkg::*;

    // Lookup.
    index_t lookup_index;
    tag_t   lookup_tag;
    logic   hit;
    way_t   hit_way;
    way_t   victim_way;
    tag_t   victim_tag;
    logic   victim_dirty;

    // Meta write.
    logic   meta_we;
    way_t   meta_way;
    tag_t   meta_tag;
    logic   meta_valid;
    logic   meta_dirty;

    // Data store ports.
    index_t    rd_index;
    way_t      rd_way;
    word_sel_t rd_sel;
    word_t     rd_word;
    logic      wr_en;
    index_t    wr_index;
    way_t      wr_way;
    word_sel_t wr_sel;
    strobe_t   wr_mask;
    word_t     wr_word;

    dcache_tag_store tags0 (
        .clk          (clk),
        .resetn       (resetn),
        .index        (lookup_index),
        .tag          (lookup_tag),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty),
        .meta_we      (meta_we),
        .meta_way     (meta_way),
        .meta_tag     (meta_tag),
        .meta_valid   (meta_valid),
        .meta_dirty   (meta_dirty)
    );

    dcache_data_store data0 (
        .clk      (clk),
        .rd_index (rd_index),
        .rd_way   (rd_way),
        .rd_sel   (rd_sel),
        .rd_word  (rd_word),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_way   (wr_way),
        .wr_sel   (wr_sel),
        .wr_mask  (wr_mask),
        .wr_word  (wr_word)
    );

    dcache_ctrl ctrl0 (
        .clk           (clk),
        .resetn        (resetn),
        .dreq_valid    (dreq_valid),
        .dreq_addr     (dreq_addr),
        .dreq_strobe   (dreq_strobe),
        .dreq_data     (dreq_data),
        .dresp_addr_ok (dresp_addr_ok),
        .dresp_data_ok (dresp_data_ok),
        .dresp_data    (dresp_data),
        .creq_valid    (creq_valid),
        .creq_is_write (creq_is_write),
        .creq_addr     (creq_addr),
        .creq_data     (creq_data),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last),
        .cresp_data    (cresp_data),
        .lookup_index  (lookup_index),
        .lookup_tag    (lookup_tag),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .victim_tag    (victim_tag),
        .victim_dirty  (victim_dirty),
        .meta_we       (meta_we),
        .meta_way      (meta_way),
        .meta_tag      (meta_tag),
        .meta_valid    (meta_valid),
        .meta_dirty    (meta_dirty),
        .rd_index      (rd_index),
        .rd_way        (rd_way),
        .rd_sel        (rd_sel),
        .rd_word       (rd_word),
        .wr_en         (wr_en),
        .wr_index      (wr_index),
        .wr_way        (wr_way),
        .wr_sel        (wr_sel),
        .wr_mask       (wr_mask),
        .wr_word       (wr_word)
    );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    // Free running, starts low.
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

//--- bench/tb_dcache.sv
`timescale 1ns/1ns
`include "dcache_defs.svh"

module tb_dcache;
    import bus_pkg::*;

    localparam int PERIOD_NS   = 100;
    localparam int N_DIRECTED  = 64;
    localparam int N_RANDOM    = 400;
    localparam int MISS_CYCLES = 40;              // Writeback plus refill, with stalls.
    localparam int WAIT_LIMIT  = 4 * MISS_CYCLES;
    localparam int WATCHDOG_NS = (N_DIRECTED + N_RANDOM) * MISS_CYCLES * PERIOD_NS;
    localparam int LINE_BYTES  = 1 << `DCACHE_OFFSET_BITS;
    localparam int WORDS       = LINE_BYTES / 4;
    localparam int SET_STRIDE  = 1 << (`DCACHE_OFFSET_BITS + `DCACHE_INDEX_BITS);

    logic    clk;
    logic    resetn;
    logic    dreq_valid;
    addr_t   dreq_addr;
    strobe_t dreq_strobe;
    word_t   dreq_data;
    logic    dresp_addr_ok;
    logic    dresp_data_ok;
    word_t   dresp_data;
    logic    creq_valid;
    logic    creq_is_write;
    addr_t   creq_addr;
    word_t   creq_data;
    logic    cresp_ready;
    logic    cresp_last;
    word_t   cresp_data;

    word_t shadow [addr_t];    // Expected memory image.
    word_t mem_model [addr_t]; // Words written back by the cache.
    word_t exp_q [$];
    logic  rd_q [$];
    word_t exp_word;
    logic  exp_read;

    int issued_count   = 0;
    int accepted_count = 0;
    int resp_count     = 0;
    int wb_count       = 0;
    int cycle_no       = 0;
    int accept_cycle   = 0;
    int last_latency   = 0;

    tb_clock #(.PERIOD_NS(PERIOD_NS)) clock0 (.clk(clk));

    dcache dut0 (
        .clk           (clk),
        .resetn        (resetn),
        .dreq_valid    (dreq_valid),
        .dreq_addr     (dreq_addr),
        .dreq_strobe   (dreq_strobe),
        .dreq_data     (dreq_data),
        .dresp_addr_ok (dresp_addr_ok),
        .dresp_data_ok (dresp_data_ok),
        .dresp_data    (dresp_data),
        .creq_valid    (creq_valid),
        .creq_is_write (creq_is_write),
        .creq_addr     (creq_addr),
        .creq_data     (creq_data),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last),
        .cresp_data    (cresp_data)
    );

    // ========================================================================
    // Reference model
    // ========================================================================

    // Power-up memory content.
    function automatic word_t init_word(input addr_t a);
        return a ^ {a[7:0], a[15:8], a[23:16], a[31:24]} ^ 32'h6c3e_91a5;
    endfunction

    function automatic word_t shadow_word(input addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return init_word(a);
    endfunction

    function automatic word_t mem_word(input addr_t a);
        if (mem_model.exists(a)) begin
            return mem_model[a];
        end
        return init_word(a);
    endfunction

    // Applies a strobed write and returns the word that the core then sees.
    function automatic word_t ref_access(input addr_t addr, input strobe_t strobe,
                                         input word_t data);
        addr_t wa;
        word_t cur;
        wa  = {addr[31:2], 2'b00};
        cur = shadow_word(wa);
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                cur[8*b +: 8] = data[8*b +: 8];
            end
        end
        if (strobe != 4'b0000) begin
            shadow[wa] = cur;
        end
        return cur;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("error at %0t ns: %s is %h, expected %h",
                                     $time, name, actual, expected));
        end
    endtask

    // One request on the data bus, returns after its data_ok.
    task automatic access(input addr_t addr, input strobe_t strobe, input word_t data);
        int waited;
        int target;
        exp_q.push_back(ref_access(addr, strobe, data));
        rd_q.push_back(strobe == 4'b0000);
        issued_count++;
        target = issued_count;
        @(negedge clk);
        dreq_valid  = 1'b1;
        dreq_addr   = addr;
        dreq_strobe = strobe;
        dreq_data   = data;
        waited = 0;
        while (accepted_count != target) begin
            if (waited == WAIT_LIMIT) report_failure("request was never accepted");
            @(negedge clk);
            waited++;
        end
        dreq_valid = 1'b0;
        waited = 0;
        while (resp_count != target) begin
            if (waited == WAIT_LIMIT) report_failure("request got no dresp_data_ok");
            @(negedge clk);
            waited++;
        end
    endtask

    // ========================================================================
    // Response checker at each rising edge
    // ========================================================================

    always @(posedge clk) begin
        if (!resetn) begin
            cycle_no++;
            if (dreq_valid && dresp_addr_ok) begin
                accept_cycle = cycle_no;
                accepted_count++;
            end
            if (dresp_data_ok) begin
                if (resp_count == accepted_count) begin
                    report_failure("dresp_data_ok seen with no outstanding request");
                end else begin
                    exp_word = exp_q.pop_front();
                    exp_read = rd_q.pop_front();
                    if (exp_read) begin
                        check_value("dresp_data", dresp_data, exp_word);
                    end
                    last_latency = cycle_no - accept_cycle;
                    resp_count++;
                end
            end
        end
    end

    // ========================================================================
    // Burst memory with random stalls
    // ========================================================================

    initial begin
        int    beat;
        addr_t a;
        cresp_ready = 1'b0;
        cresp_last  = 1'b0;
        cresp_data  = '0;
        beat = 0;
        forever begin
            @(negedge clk);
            cresp_ready = 1'b0;
            cresp_last  = 1'b0;
            if (creq_valid === 1'b1) begin
                a = creq_addr + addr_t'(4 * beat);
                if (($urandom % 4) != 0) begin
                    cresp_ready = 1'b1;
                    cresp_last  = beat == WORDS - 1;
                    if (creq_is_write) begin
                        check_value("creq_data", creq_data, shadow_word(a)); // Victim word.
                        mem_model[a] = creq_data;
                    end else begin
                        cresp_data = mem_word(a);
                    end
                    if (beat == WORDS - 1) begin
                        beat = 0;
                        wb_count += creq_is_write ? 1 : 0;
                    end else begin
                        beat++;
                    end
                end
            end else begin
                beat = 0;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before the tests finished");
    end

    // ========================================================================
    // Stimulus
    // ========================================================================

    initial begin
        addr_t   a;
        strobe_t s;
        int      wb_before;
        void'($urandom(3184));
        resetn      = 1'b1;
        dreq_valid  = 1'b0;
        dreq_addr   = '0;
        dreq_strobe = '0;
        dreq_data   = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn = 1'b0;
        @(negedge clk);

        check_value("dresp_addr_ok", 32'(dresp_addr_ok), 32'd1);
        check_value("dresp_data_ok", 32'(dresp_data_ok), 32'd0);
        check_value("creq_valid", 32'(creq_valid), 32'd0);

        // Cold miss, then the same word again as a hit.
        access(32'h0000_1008, 4'b0000, '0);
        access(32'h0000_1008, 4'b0000, '0);
        check_value("read hit latency", 32'(last_latency), 32'd2);

        // Partial writes on a hit and on a miss.
        access(32'h0000_1004, 4'b0011, 32'h1122_3344);
        check_value("write hit latency", 32'(last_latency), 32'd2);
        access(32'h0000_1004, 4'b1000, 32'haabb_ccdd);
        access(32'h0000_1004, 4'b0000, '0);
        access(32'h0000_2014, 4'b0110, 32'hdead_beef);
        access(32'h0000_2014, 4'b0000, '0);

        // Eight dirty lines in one set.
        wb_before = wb_count;
        for (int k = 0; k < 8; k++) begin
            a = 32'h0001_0000 + addr_t'(k * SET_STRIDE + 2 * LINE_BYTES);
            access(a + addr_t'(4 * (k % WORDS)), 4'b1111, $urandom);
            access(a + addr_t'(4 * ((k + 1) % WORDS)), 4'b0101, $urandom);
        end
        for (int k = 0; k < 8; k++) begin
            a = 32'h0001_0000 + addr_t'(k * SET_STRIDE + 2 * LINE_BYTES);
            for (int w = 0; w < WORDS; w++) begin
                access(a + addr_t'(4 * w), 4'b0000, '0);
            end
        end
        if (wb_count == wb_before) report_failure("no dirty line was written back");

        // Random mix over a 1 KB window.
        for (int i = 0; i < N_RANDOM; i++) begin
            a = 32'h0000_8000 + (($urandom % 256) << 2);
            if (($urandom % 2) == 0) begin
                s = 4'b0000;
            end else begin
                s = 4'($urandom % 15 + 1);
            end
            access(a, s, $urandom);
        end

        repeat (8) @(negedge clk); // Catch any late data_ok.
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- all.f
+incdir+source
source/bus_pkg.sv
source/cache_pkg.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_ctrl.sv
source/dcache.sv
bench/tb_clock.sv
bench/tb_dcache.sv

//--- Makefile
TOP = tb_dcache

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the obj_dir build folder"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f all.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
